// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_debug_unit
LOG       ?= sim.log
SEED      ?= 90
FLIST     ?= uart_debug_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# one binary per top module, rebuilt only when a source, header or the list changes
$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $* -GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/debug_unit_config.svh
`ifndef DEBUG_UNIT_CONFIG_SVH
`define DEBUG_UNIT_CONFIG_SVH

// command bytes sent by the host
`define DU_CMD_LOAD    8'h01                // start instruction loading
`define DU_CMD_DEBUG   8'h02                // enter step mode
`define DU_CMD_RUN     8'h04                // continuous mode
`define DU_CMD_STEP    8'h08                // one step plus dump
`define DU_CMD_END     8'h10                // last dump, leave debug

// this word is still forwarded to fetch
`define DU_HALT_INSTR  32'hFFFF_FFFF

`define DU_INSTR_BYTES 4                    // msb first on the wire
`define DU_SNAP_BYTES  30                   // 18 + 4 + 5 + 3

`endif

// File: common/debug_unit_pkg.sv
package debug_unit_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] instr_t;

    typedef struct packed {
        logic [31:0] reg_da;
        logic [31:0] reg_db;
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [15:0] immediate;
        logic [31:0] addr2jump;             // lowest bits, sent first
    } id_ex_t;

    typedef struct packed {
        logic [31:0] alu_result;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] data2mem;
        logic [7:0]  data_addr;
    } mem_wb_t;

    // single-bit flags on top, then the 2-bit selects, then pad
    typedef struct packed {
        logic [8:0]  flags;                 // jump .. reg_write
        logic [9:0]  selects;               // alu_src .. fw_b
        logic [4:0]  pad;
    } control_t;

    // byte 0 of the dump is byte 0 of id_ex
    typedef struct packed {
        control_t control;
        mem_wb_t  mem_wb;
        ex_mem_t  ex_mem;
        id_ex_t   id_ex;
    } snapshot_t;

    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_LOAD,
        MODE_DEBUG,
        MODE_RUN,
        MODE_DUMP_WAIT
    } du_mode_e;

endpackage

// File: dump/snapshot_capture.sv
`timescale 1ns/100ps

module snapshot_capture
    import debug_unit_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_dump_valid,
    output logic        o_dump_ready,
    input  logic [31:0] i_reg_da,
    input  logic [31:0] i_reg_db,
    input  logic [5:0]  i_opcode,
    input  logic [4:0]  i_rs,
    input  logic [4:0]  i_rt,
    input  logic [4:0]  i_rd,
    input  logic [4:0]  i_shamt,
    input  logic [5:0]  i_funct,
    input  logic [15:0] i_immediate,
    input  logic [31:0] i_addr2jump,
    input  logic [31:0] i_alu_result,
    input  logic [31:0] i_data2mem,
    input  logic [7:0]  i_data_addr,
    input  logic        i_jump,
    input  logic        i_branch,
    input  logic        i_reg_dst,
    input  logic        i_mem2reg,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  logic        i_imm_flag,
    input  logic        i_sign_flag,
    input  logic        i_reg_write,
    input  logic [1:0]  i_alu_src,
    input  logic [1:0]  i_width,
    input  logic [1:0]  i_alu_op,
    input  logic [1:0]  i_fw_a,
    input  logic [1:0]  i_fw_b,
    output snapshot_t   o_snap,
    output logic        o_snap_valid,
    input  logic        i_snap_ready
);

    snapshot_t snap_in;
    logic      full_q;
    logic      capture;

    always_comb begin
        snap_in.id_ex   = {i_reg_da, i_reg_db, i_opcode, i_rs, i_rt, i_rd, i_shamt,
                           i_funct, i_immediate, i_addr2jump};
        snap_in.ex_mem  = i_alu_result;
        snap_in.mem_wb  = {i_data2mem, i_data_addr};
        snap_in.control = {i_jump, i_branch, i_reg_dst, i_mem2reg, i_mem_read, i_mem_write,
                           i_imm_flag, i_sign_flag, i_reg_write, i_alu_src, i_width,
                           i_alu_op, i_fw_a, i_fw_b, 5'b0};     // pad goes out as zero
    end

    assign capture = i_dump_valid && o_dump_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (o_snap_valid && i_snap_ready) begin
            full_q <= 1'b0;                                     // serializer took it
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_snap <= snap_in;                                  // latches at request edge
        end
    end

    assign o_dump_ready = !full_q;
    assign o_snap_valid = full_q;

endmodule

// File: dump/snapshot_serializer.sv
`timescale 1ns/100ps
`include "debug_unit_config.svh"

module snapshot_serializer
    import debug_unit_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  snapshot_t i_snap,
    input  logic      i_snap_valid,
    output logic      o_snap_ready,
    output byte_t     o_tx_data,
    output logic      o_tx_valid,
    input  logic      i_tx_ready
);

    localparam int CNT_W  = $clog2(`DU_SNAP_BYTES);
    localparam int BYTE_W = $bits(byte_t);
    localparam int SNAP_W = $bits(snapshot_t);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`DU_SNAP_BYTES - 1);

    logic [SNAP_W-1:0] shift_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              busy_q;
    logic              load;
    logic              tx_fire;

    assign load    = i_snap_valid && o_snap_ready;
    assign tx_fire = o_tx_valid && i_tx_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (load) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (tx_fire) begin
            if (cnt_q == LAST_BYTE) begin
                busy_q <= 1'b0;                                 // byte 30 accepted
                cnt_q  <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // low byte always on the output, shifted down per handshake
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= i_snap;
        end else if (tx_fire) begin
            shift_q <= shift_q >> BYTE_W;
        end
    end

    assign o_tx_data    = shift_q[BYTE_W-1:0];                  // stable while stalled
    assign o_tx_valid   = busy_q;
    assign o_snap_ready = !busy_q;

endmodule

// File: logic/cmd_decoder.sv
`timescale 1ns/100ps
`include "debug_unit_config.svh"

module cmd_decoder
    import debug_unit_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  byte_t  i_rx_data,
    input  logic   i_rx_valid,
    input  logic   i_end,                   // program finished, run mode only
    output instr_t o_instr,
    output logic   o_instr_valid,
    output logic   o_step,
    output logic   o_start,
    output logic   o_dump_valid,
    output logic   o_dump_debug,
    input  logic   i_dump_ready
);

    localparam int CNT_W = $clog2(`DU_INSTR_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`DU_INSTR_BYTES - 1);

    du_mode_e         mode_q;
    logic [CNT_W-1:0] byte_cnt_q;
    instr_t           instr_q;
    instr_t           instr_next;
    logic             dump_debug_q;
    logic             last_byte;

    assign instr_next = {instr_q[23:0], i_rx_data};             // shift in, msb first
    assign last_byte  = i_rx_valid && (byte_cnt_q == LAST_BYTE);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q        <= MODE_IDLE;
            byte_cnt_q    <= '0;
            o_instr_valid <= 1'b0;
            o_step        <= 1'b0;
            dump_debug_q  <= 1'b0;
        end else begin
            o_instr_valid <= 1'b0;                              // both are single pulses
            o_step        <= 1'b0;
            case (mode_q)
                MODE_IDLE: begin
                    byte_cnt_q <= '0;
                    if (i_rx_valid) begin
                        case (i_rx_data)
                            `DU_CMD_LOAD:  mode_q <= MODE_LOAD;
                            `DU_CMD_DEBUG: mode_q <= MODE_DEBUG;
                            `DU_CMD_RUN:   mode_q <= MODE_RUN;
                            default:       mode_q <= MODE_IDLE; // unknown byte
                        endcase
                    end
                end
                MODE_LOAD: begin
                    if (last_byte) begin
                        byte_cnt_q    <= '0;
                        o_instr_valid <= 1'b1;
                        if (instr_next == `DU_HALT_INSTR) begin
                            mode_q <= MODE_IDLE;                // halt word ends loading
                        end
                    end else if (i_rx_valid) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end
                end
                MODE_DEBUG: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == `DU_CMD_STEP) begin
                            o_step       <= 1'b1;
                            dump_debug_q <= 1'b1;               // come back for more steps
                            mode_q       <= MODE_DUMP_WAIT;
                        end else if (i_rx_data == `DU_CMD_END) begin
                            dump_debug_q <= 1'b0;               // final dump then idle
                            mode_q       <= MODE_DUMP_WAIT;
                        end
                    end
                end
                MODE_RUN: begin
                    if (i_end) begin
                        dump_debug_q <= 1'b0;
                        mode_q       <= MODE_DUMP_WAIT;
                    end
                end
                MODE_DUMP_WAIT: begin
                    // rx bytes are dropped while the request is pending
                    if (i_dump_ready) begin
                        mode_q <= dump_debug_q ? MODE_DEBUG : MODE_IDLE;
                    end
                end
                default: begin
                    mode_q <= MODE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mode_q == MODE_LOAD && i_rx_valid) begin
            instr_q <= instr_next;
        end
    end

    assign o_instr      = instr_q;
    assign o_dump_valid = (mode_q == MODE_DUMP_WAIT);           // held until ready
    assign o_dump_debug = dump_debug_q;
    assign o_start      = (mode_q == MODE_RUN) || (mode_q == MODE_DEBUG) ||
                          (mode_q == MODE_DUMP_WAIT);

endmodule

// File: logic/uart_debug_unit.sv
`timescale 1ns/100ps

module uart_debug_unit
    import debug_unit_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  byte_t       i_rx_data,
    input  logic        i_rx_valid,
    input  logic        i_end,
    input  logic [31:0] i_reg_da,
    input  logic [31:0] i_reg_db,
    input  logic [5:0]  i_opcode,
    input  logic [4:0]  i_rs,
    input  logic [4:0]  i_rt,
    input  logic [4:0]  i_rd,
    input  logic [4:0]  i_shamt,
    input  logic [5:0]  i_funct,
    input  logic [15:0] i_immediate,
    input  logic [31:0] i_addr2jump,
    input  logic [31:0] i_alu_result,
    input  logic [31:0] i_data2mem,
    input  logic [7:0]  i_data_addr,
    input  logic        i_jump,
    input  logic        i_branch,
    input  logic        i_reg_dst,
    input  logic        i_mem2reg,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  logic        i_imm_flag,
    input  logic        i_sign_flag,
    input  logic        i_reg_write,
    input  logic [1:0]  i_alu_src,
    input  logic [1:0]  i_width,
    input  logic [1:0]  i_alu_op,
    input  logic [1:0]  i_fw_a,
    input  logic [1:0]  i_fw_b,
    output instr_t      o_instr,
    output logic        o_instr_valid,
    output logic        o_step,
    output logic        o_start,
    output byte_t       o_tx_data,
    output logic        o_tx_valid,
    input  logic        i_tx_ready
);

    logic      dump_valid;
    logic      dump_ready;
    snapshot_t snap;
    logic      snap_valid;
    logic      snap_ready;

    cmd_decoder u_cmd_decoder (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rx_data     (i_rx_data),
        .i_rx_valid    (i_rx_valid),
        .i_end         (i_end),
        .o_instr       (o_instr),
        .o_instr_valid (o_instr_valid),
        .o_step        (o_step),
        .o_start       (o_start),
        .o_dump_valid  (dump_valid),
        .o_dump_debug  (),                  // only steers the decoder itself
        .i_dump_ready  (dump_ready)
    );

    // latch inputs share their names with the top ports
    snapshot_capture u_snapshot_capture (
        .i_dump_valid (dump_valid),
        .o_dump_ready (dump_ready),
        .o_snap       (snap),
        .o_snap_valid (snap_valid),
        .i_snap_ready (snap_ready),
        .*
    );

    snapshot_serializer u_snapshot_serializer (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_snap       (snap),
        .i_snap_valid (snap_valid),
        .o_snap_ready (snap_ready),
        .o_tx_data    (o_tx_data),
        .o_tx_valid   (o_tx_valid),
        .i_tx_ready   (i_tx_ready)
    );

endmodule

// File: sim/debug_unit_assertions.sv
`timescale 1ns/100ps

module debug_unit_assertions
    import debug_unit_pkg::*;
(
    input logic  clk,
    input logic  i_rst_n,
    input byte_t i_tx_data,
    input logic  i_tx_valid,
    input logic  i_tx_ready,
    input logic  i_step,
    input logic  i_instr_valid
);

    tx_hold_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_data))
        else $error("tx byte dropped or changed while the transmitter was stalled");

    step_pulse_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_step |=> !i_step)
        else $error("step pulse lasted more than one cycle");

    // loading and dumping never overlap
    instr_tx_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_instr_valid && i_tx_valid))
        else $error("instruction handed over while a dump was being sent");

endmodule

bind uart_debug_unit debug_unit_assertions u_debug_unit_assertions (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_tx_data     (o_tx_data),
    .i_tx_valid    (o_tx_valid),
    .i_tx_ready    (i_tx_ready),
    .i_step        (o_step),
    .i_instr_valid (o_instr_valid)
);

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 10
) (
    output logic clk,
    output logic o_rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        o_rst_n <= 1'b1;                                        // released on a rising edge
    end

endmodule

// File: sim/tb_uart_debug_unit.sv
`timescale 1ns/100ps
`include "debug_unit_config.svh"

module tb_uart_debug_unit
    import debug_unit_pkg::*;
#(
    parameter int SEED = 90
);

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 10;
    localparam int DUMP_LIMIT  = 400;                           // cycles allowed per stalled dump
    localparam int NUM_DUMPS   = 6;
    localparam int CTRL_CYCLES = 400;                           // rx traffic and checks
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
                                 (RST_CYCLES + CTRL_CYCLES + NUM_DUMPS * DUMP_LIMIT);

    logic        clk;
    logic        i_rst_n;
    byte_t       i_rx_data;
    logic        i_rx_valid;
    logic        i_end;
    logic        i_tx_ready;
    logic [31:0] i_reg_da, i_reg_db, i_addr2jump, i_alu_result, i_data2mem;
    logic [15:0] i_immediate;
    logic [7:0]  i_data_addr;
    logic [5:0]  i_opcode, i_funct;
    logic [4:0]  i_rs, i_rt, i_rd, i_shamt;
    logic [1:0]  i_alu_src, i_width, i_alu_op, i_fw_a, i_fw_b;
    logic        i_jump, i_branch, i_reg_dst, i_mem2reg, i_mem_read, i_mem_write;
    logic        i_imm_flag, i_sign_flag, i_reg_write;
    instr_t      o_instr;
    logic        o_instr_valid;
    logic        o_step;
    logic        o_start;
    byte_t       o_tx_data;
    logic        o_tx_valid;
    logic [31:0] rng_state;

    tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RST_CYCLES(RST_CYCLES)) u_clock_gen (
        .clk     (clk),
        .o_rst_n (i_rst_n)
    );

    uart_debug_unit DUT (.*);

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;                                          // xorshift32
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // byte k of the dump sits in bits [8k+7:8k]
    function automatic logic [8*`DU_SNAP_BYTES-1:0] expected_dump();
        logic [143:0] id_ex;
        logic [39:0]  mem_wb;
        logic [23:0]  control;
        id_ex   = {i_reg_da, i_reg_db, i_opcode, i_rs, i_rt, i_rd, i_shamt, i_funct,
                   i_immediate, i_addr2jump};
        mem_wb  = {i_data2mem, i_data_addr};
        control = {i_jump, i_branch, i_reg_dst, i_mem2reg, i_mem_read, i_mem_write,
                   i_imm_flag, i_sign_flag, i_reg_write, i_alu_src, i_width, i_alu_op,
                   i_fw_a, i_fw_b, 5'b0};
        return {control, mem_wb, i_alu_result, id_ex};
    endfunction

    task automatic stop_with_error();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic check_idle_outputs();
        @(negedge clk);
        compare_bit("o_instr_valid", o_instr_valid, 1'b0);
        compare_bit("o_step", o_step, 1'b0);
        compare_bit("o_start", o_start, 1'b0);
        compare_bit("o_tx_valid", o_tx_valid, 1'b0);
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge clk);
        i_rx_data  <= b;
        i_rx_valid <= 1'b1;
        @(posedge clk);
        i_rx_valid <= 1'b0;                                     // taken on this edge
    endtask

    task automatic send_instr(input instr_t w);
        for (int b = 0; b < `DU_INSTR_BYTES; b++) begin
            send_byte(w[31 - 8*b -: 8]);                        // msb first
            @(negedge clk);
            compare_bit("o_instr_valid", o_instr_valid, b == `DU_INSTR_BYTES - 1);
        end
        compare_instr("o_instr", o_instr, w);
    endtask

    task automatic randomize_latches();
        logic [31:0] r;
        r = next_random();
        @(posedge clk);
        i_reg_da     <= next_random();
        i_reg_db     <= next_random();
        i_addr2jump  <= next_random();
        i_alu_result <= next_random();
        i_data2mem   <= next_random();
        {i_opcode, i_rs, i_rt, i_rd, i_shamt, i_funct} <= next_random();
        {i_immediate, i_data_addr, i_alu_src, i_width, i_alu_op, i_fw_a} <= next_random();
        {i_jump, i_branch, i_reg_dst, i_mem2reg, i_mem_read, i_mem_write, i_imm_flag,
         i_sign_flag, i_reg_write, i_fw_b} <= r[10:0];
    endtask

    // tx ready is low between dumps, so no byte can slip past
    task automatic collect_dump(input logic stall);
        logic [8*`DU_SNAP_BYTES-1:0] exp;
        logic [31:0]                 r;
        int                          n;
        int                          cycles;
        exp    = expected_dump();
        n      = 0;
        cycles = 0;
        randomize_latches();                                    // pipeline moves on after the request
        while (n < `DU_SNAP_BYTES && cycles < DUMP_LIMIT) begin
            r = next_random();
            @(posedge clk);
            i_tx_ready <= stall ? r[0] : 1'b1;
            @(negedge clk);
            if (o_tx_valid && i_tx_ready) begin
                compare_byte($sformatf("o_tx_data[%0d]", n), o_tx_data, exp[8*n +: 8]);
                n++;
            end
            cycles++;
        end
        if (n != `DU_SNAP_BYTES) begin
            $display("dump stopped after %0d of %0d bytes", n, `DU_SNAP_BYTES);
            stop_with_error();
        end
        @(posedge clk);
        i_tx_ready <= 1'b0;
        @(negedge clk);
        compare_bit("o_tx_valid", o_tx_valid, 1'b0);           // no extra byte
    endtask

    task automatic step_and_dump(input logic stall);
        send_byte(`DU_CMD_STEP);
        @(negedge clk);
        compare_bit("o_step", o_step, 1'b1);
        @(negedge clk);
        compare_bit("o_step", o_step, 1'b0);
        collect_dump(stall);
        compare_bit("o_start", o_start, 1'b1);                 // back in step mode
    endtask

    task automatic test_load();
        instr_t w;
        send_byte(`DU_CMD_LOAD);
        for (int i = 0; i < 6; i++) begin
            w = (i == 5) ? `DU_HALT_INSTR : next_random();
            send_instr(w);
        end
        for (int i = 0; i < 4; i++) begin
            send_byte(8'hA5 ^ 8'(i * 8'h33));                  // no command code among these
            check_idle_outputs();
        end
    endtask

    task automatic test_run();
        randomize_latches();
        send_byte(`DU_CMD_RUN);
        @(negedge clk);
        compare_bit("o_start", o_start, 1'b1);
        @(posedge clk);
        i_end <= 1'b1;
        @(posedge clk);
        i_end <= 1'b0;
        collect_dump(1'b0);
        compare_bit("o_start", o_start, 1'b0);
    endtask

    task automatic test_debug_step();
        send_byte(`DU_CMD_DEBUG);
        for (int s = 0; s < 2; s++) begin
            randomize_latches();                                // new values for every step
            step_and_dump(1'b0);
        end
    endtask

    task automatic test_end_debug();
        randomize_latches();
        send_byte(`DU_CMD_END);
        collect_dump(1'b0);
        compare_bit("o_start", o_start, 1'b0);
        send_byte(`DU_CMD_STEP);
        repeat (3) check_idle_outputs();
    endtask

    task automatic test_back_pressure();
        send_byte(`DU_CMD_DEBUG);
        randomize_latches();
        step_and_dump(1'b1);
        randomize_latches();
        send_byte(`DU_CMD_END);
        collect_dump(1'b1);
        compare_bit("o_start", o_start, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_with_error();
    end

    initial begin
        rng_state  = 32'(SEED);
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        i_end      = 1'b0;
        i_tx_ready = 1'b0;
        {i_reg_da, i_reg_db, i_opcode, i_rs, i_rt, i_rd, i_shamt, i_funct, i_immediate,
         i_addr2jump, i_alu_result, i_data2mem, i_data_addr, i_jump, i_branch, i_reg_dst,
         i_mem2reg, i_mem_read, i_mem_write, i_imm_flag, i_sign_flag, i_reg_write,
         i_alu_src, i_width, i_alu_op, i_fw_a, i_fw_b} = '0;
        @(posedge i_rst_n);
        check_idle_outputs();
        test_load();
        test_run();
        test_debug_step();
        test_end_debug();
        test_back_pressure();
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: uart_debug_unit.f
+incdir+common
common/debug_unit_pkg.sv
logic/cmd_decoder.sv
dump/snapshot_capture.sv
dump/snapshot_serializer.sv
logic/uart_debug_unit.sv
sim/tb_clock_gen.sv
sim/debug_unit_assertions.sv
sim/tb_uart_debug_unit.sv
